// File: rtl/mem_geom_pkg.sv
// memory-side geometry of the SDRAM address and command pins
`default_nettype none

package mem_geom_pkg;

    // ************************************************************
    // pin counts on the memory side of the address/command bus
    // ************************************************************

    // row/column address pins
    localparam int MEM_ADDR_WIDTH = 13;

    // bank address pins
    localparam int MEM_BANK_WIDTH = 2;

    // one chip select per rank
    localparam int MEM_CS_WIDTH = 1;

    localparam int MEM_CKE_WIDTH = 1;
    localparam int MEM_ODT_WIDTH = 1;

    // ************************************************************
    // single-beat vectors, one full-rate memory clock each
    // ************************************************************

    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [MEM_BANK_WIDTH-1:0] mem_bank_t;
    typedef logic [MEM_CS_WIDTH-1:0]   mem_cs_t;
    typedef logic [MEM_CKE_WIDTH-1:0]  mem_cke_t;
    typedef logic [MEM_ODT_WIDTH-1:0]  mem_odt_t;

endpackage

`default_nettype wire

// File: rtl/afi_cmd_pkg.sv
// half-rate controller word types, conversion phase and inactive command values
`default_nettype none

package afi_cmd_pkg;

    // ************************************************************
    // half-rate word fields, two beats each, low half is beat 0
    // ************************************************************

    // ras_n, cas_n and we_n are one pin each on the memory side
    localparam int AFI_CTL_WIDTH = 2;

    typedef logic [2*mem_geom_pkg::MEM_ADDR_WIDTH-1:0] afi_addr_t;
    typedef logic [2*mem_geom_pkg::MEM_BANK_WIDTH-1:0] afi_bank_t;
    typedef logic [2*mem_geom_pkg::MEM_CS_WIDTH-1:0]   afi_cs_t;
    typedef logic [2*mem_geom_pkg::MEM_CKE_WIDTH-1:0]  afi_cke_t;
    typedef logic [2*mem_geom_pkg::MEM_ODT_WIDTH-1:0]  afi_odt_t;
    typedef logic [AFI_CTL_WIDTH-1:0]                  afi_ctl_t;

    // the sync state waits for reset release, after which load and
    // second beat alternate for as long as reset stays high
    typedef enum logic [1:0] {
        PHASE_SYNC   = 2'd0,
        PHASE_LOAD   = 2'd1,
        PHASE_SECOND = 2'd2
    } ac_phase_t;

    // ************************************************************
    // values driven while the command pins are not enabled
    // ************************************************************

    // deselect, which is a NOP for every rank
    localparam mem_geom_pkg::mem_cs_t CMD_INACTIVE_CS_N = '1;

    localparam logic CMD_INACTIVE_CTL_N = 1'b1;

    localparam mem_geom_pkg::mem_addr_t CMD_INACTIVE_ADDR = '0;

endpackage

`default_nettype wire

// File: rtl/ac_cmd_if.sv
// one full-rate address/command beat passed from the serializer to the output stage
`timescale 1ns/1ps
`default_nettype none

interface ac_cmd_if;

    import mem_geom_pkg::*;

    mem_addr_t addr;
    mem_bank_t bank;
    mem_cs_t   cs_n;
    mem_cke_t  cke;
    mem_odt_t  odt;
    logic      ras_n;
    logic      cas_n;
    logic      we_n;

    // the serializer drives a fresh beat on every clock
    modport src (
        output addr,
        output bank,
        output cs_n,
        output cke,
        output odt,
        output ras_n,
        output cas_n,
        output we_n
    );

    modport dst (
        input addr,
        input bank,
        input cs_n,
        input cke,
        input odt,
        input ras_n,
        input cas_n,
        input we_n
    );

endinterface

`default_nettype wire

// File: rtl/ac_phase_gen.sv
// derives the half-rate load phase from the release of reset
`timescale 1ns/1ps
`default_nettype none

module ac_phase_gen (
    input  logic pll_mem_clk,
    input  logic rst_n,
    output logic load
);

    import afi_cmd_pkg::*;

    logic      rst_seen;
    logic      rst_seen_q;
    ac_phase_t phase;

    // ************************************************************
    // reset release detector
    // ************************************************************

    // both flops follow rst_n itself, so they must not be cleared by it
    always_ff @(posedge pll_mem_clk)
    begin
        rst_seen   <= rst_n;
        rst_seen_q <= rst_seen;
    end

    // ************************************************************
    // phase state machine
    // ************************************************************

    always_ff @(posedge pll_mem_clk)
    begin
        if (!rst_n)
        begin
            phase <= PHASE_SYNC;
        end
        else if (rst_seen && !rst_seen_q)
        begin
            // first cycle after release fixes the word boundary
            phase <= PHASE_LOAD;
        end
        else
        begin
            case (phase)
                PHASE_SYNC:   phase <= PHASE_SYNC;
                PHASE_LOAD:   phase <= PHASE_SECOND;
                PHASE_SECOND: phase <= PHASE_LOAD;
                default:      phase <= PHASE_SYNC;
            endcase
        end
    end

    // the controller word is taken on every edge where this is high
    assign load = (phase == PHASE_LOAD);

endmodule

`default_nettype wire

// File: rtl/ac_beat_serializer.sv
// splits each half-rate command word into two full-rate beats, low half first
`timescale 1ns/1ps
`default_nettype none

module ac_beat_serializer (
    input  logic                 pll_mem_clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  afi_cmd_pkg::afi_addr_t afi_addr,
    input  afi_cmd_pkg::afi_bank_t afi_bank,
    input  afi_cmd_pkg::afi_cs_t   afi_cs_n,
    input  afi_cmd_pkg::afi_cke_t  afi_cke,
    input  afi_cmd_pkg::afi_odt_t  afi_odt,
    input  afi_cmd_pkg::afi_ctl_t  afi_ras_n,
    input  afi_cmd_pkg::afi_ctl_t  afi_cas_n,
    input  afi_cmd_pkg::afi_ctl_t  afi_we_n,
    ac_cmd_if.src                beat
);

    import mem_geom_pkg::*;
    import afi_cmd_pkg::*;

    // high halves of the word taken at the last load
    mem_addr_t hi_addr;
    mem_bank_t hi_bank;
    mem_cs_t   hi_cs_n;
    mem_cke_t  hi_cke;
    mem_odt_t  hi_odt;
    logic      hi_ras_n;
    logic      hi_cas_n;
    logic      hi_we_n;

    // set in the cycle where beat 1 is due
    logic      second_due;

    // ************************************************************
    // beat 1 holding registers
    // ************************************************************

    always_ff @(posedge pll_mem_clk)
    begin
        if (load)
        begin
            hi_addr  <= afi_addr[2*MEM_ADDR_WIDTH-1:MEM_ADDR_WIDTH];
            hi_bank  <= afi_bank[2*MEM_BANK_WIDTH-1:MEM_BANK_WIDTH];
            hi_cs_n  <= afi_cs_n[2*MEM_CS_WIDTH-1:MEM_CS_WIDTH];
            hi_cke   <= afi_cke[2*MEM_CKE_WIDTH-1:MEM_CKE_WIDTH];
            hi_odt   <= afi_odt[2*MEM_ODT_WIDTH-1:MEM_ODT_WIDTH];
            hi_ras_n <= afi_ras_n[1];
            hi_cas_n <= afi_cas_n[1];
            hi_we_n  <= afi_we_n[1];
        end
    end

    always_ff @(posedge pll_mem_clk)
    begin
        if (!rst_n)
        begin
            second_due <= 1'b0;
        end
        else
        begin
            second_due <= load;
        end
    end

    // ************************************************************
    // beat register
    // ************************************************************

    // beat 0 goes out straight from the word, beat 1 from the holding
    // registers one cycle later; the beat holds until the first load
    always_ff @(posedge pll_mem_clk)
    begin
        if (!rst_n)
        begin
            beat.addr  <= CMD_INACTIVE_ADDR;
            beat.bank  <= '0;
            beat.cs_n  <= CMD_INACTIVE_CS_N;
            beat.cke   <= '0;
            beat.odt   <= '0;
            beat.ras_n <= CMD_INACTIVE_CTL_N;
            beat.cas_n <= CMD_INACTIVE_CTL_N;
            beat.we_n  <= CMD_INACTIVE_CTL_N;
        end
        else if (load)
        begin
            beat.addr  <= afi_addr[MEM_ADDR_WIDTH-1:0];
            beat.bank  <= afi_bank[MEM_BANK_WIDTH-1:0];
            beat.cs_n  <= afi_cs_n[MEM_CS_WIDTH-1:0];
            beat.cke   <= afi_cke[MEM_CKE_WIDTH-1:0];
            beat.odt   <= afi_odt[MEM_ODT_WIDTH-1:0];
            beat.ras_n <= afi_ras_n[0];
            beat.cas_n <= afi_cas_n[0];
            beat.we_n  <= afi_we_n[0];
        end
        else if (second_due)
        begin
            beat.addr  <= hi_addr;
            beat.bank  <= hi_bank;
            beat.cs_n  <= hi_cs_n;
            beat.cke   <= hi_cke;
            beat.odt   <= hi_odt;
            beat.ras_n <= hi_ras_n;
            beat.cas_n <= hi_cas_n;
            beat.we_n  <= hi_we_n;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ac_output_stage.sv
// registers command beats onto the memory pins, gated by the memory clock enables
`timescale 1ns/1ps
`default_nettype none

module ac_output_stage #(
    parameter int MEM_CK_WIDTH = 1
) (
    input  logic                    pll_mem_clk,
    input  logic                    rst_n,
    input  logic [MEM_CK_WIDTH-1:0] enable_mem_clk,
    ac_cmd_if.dst                   beat,
    output mem_geom_pkg::mem_addr_t mem_addr,
    output mem_geom_pkg::mem_bank_t mem_bank,
    output mem_geom_pkg::mem_cs_t   mem_cs_n,
    output mem_geom_pkg::mem_cke_t  mem_cke,
    output mem_geom_pkg::mem_odt_t  mem_odt,
    output logic                    mem_ras_n,
    output logic                    mem_cas_n,
    output logic                    mem_we_n,
    output logic                    cmd_oe,
    output logic [MEM_CK_WIDTH-1:0] mem_ck_en
);

    import afi_cmd_pkg::*;

    // any running memory clock lets commands through
    logic any_ck_en;

    assign any_ck_en = |enable_mem_clk;

    // ************************************************************
    // pin registers
    // ************************************************************

    always_ff @(posedge pll_mem_clk)
    begin
        if (!rst_n)
        begin
            mem_addr  <= CMD_INACTIVE_ADDR;
            mem_bank  <= '0;
            mem_cs_n  <= CMD_INACTIVE_CS_N;
            mem_odt   <= '0;
            mem_ras_n <= CMD_INACTIVE_CTL_N;
            mem_cas_n <= CMD_INACTIVE_CTL_N;
            mem_we_n  <= CMD_INACTIVE_CTL_N;
        end
        else if (any_ck_en)
        begin
            mem_addr  <= beat.addr;
            mem_bank  <= beat.bank;
            mem_cs_n  <= beat.cs_n;
            mem_odt   <= beat.odt;
            mem_ras_n <= beat.ras_n;
            mem_cas_n <= beat.cas_n;
            mem_we_n  <= beat.we_n;
        end
        else
        begin
            // stands in for the tri-stated pads: deselect with a quiet bus
            mem_addr  <= CMD_INACTIVE_ADDR;
            mem_bank  <= '0;
            mem_cs_n  <= CMD_INACTIVE_CS_N;
            mem_odt   <= '0;
            mem_ras_n <= CMD_INACTIVE_CTL_N;
            mem_cas_n <= CMD_INACTIVE_CTL_N;
            mem_we_n  <= CMD_INACTIVE_CTL_N;
        end
    end

    // cke must reach the memory even with its clocks stopped,
    // otherwise power-down entry and exit would be impossible
    always_ff @(posedge pll_mem_clk)
    begin
        if (!rst_n)
        begin
            mem_cke <= '0;
        end
        else
        begin
            mem_cke <= beat.cke;
        end
    end

    // ************************************************************
    // enable outputs, aligned with the beat they gate
    // ************************************************************

    always_ff @(posedge pll_mem_clk)
    begin
        if (!rst_n)
        begin
            cmd_oe    <= 1'b0;
            mem_ck_en <= '0;
        end
        else
        begin
            cmd_oe    <= any_ck_en;
            mem_ck_en <= enable_mem_clk;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ac_pads_top.sv
// half-rate to full-rate SDRAM address/command converter with gated memory pins
`timescale 1ns/1ps
`default_nettype none

module ac_pads_top #(
    parameter int MEM_CK_WIDTH = 1
) (
    input  logic                    pll_mem_clk,
    input  logic                    rst_n,
    input  logic [MEM_CK_WIDTH-1:0] enable_mem_clk,

    // half-rate controller word, low half of each field is beat 0
    input  afi_cmd_pkg::afi_addr_t  afi_addr,
    input  afi_cmd_pkg::afi_bank_t  afi_bank,
    input  afi_cmd_pkg::afi_cs_t    afi_cs_n,
    input  afi_cmd_pkg::afi_cke_t   afi_cke,
    input  afi_cmd_pkg::afi_odt_t   afi_odt,
    input  afi_cmd_pkg::afi_ctl_t   afi_ras_n,
    input  afi_cmd_pkg::afi_ctl_t   afi_cas_n,
    input  afi_cmd_pkg::afi_ctl_t   afi_we_n,

    // high on the edge where the word above is taken
    output logic                    afi_load,

    // full-rate memory pins
    output mem_geom_pkg::mem_addr_t mem_addr,
    output mem_geom_pkg::mem_bank_t mem_bank,
    output mem_geom_pkg::mem_cs_t   mem_cs_n,
    output mem_geom_pkg::mem_cke_t  mem_cke,
    output mem_geom_pkg::mem_odt_t  mem_odt,
    output logic                    mem_ras_n,
    output logic                    mem_cas_n,
    output logic                    mem_we_n,
    output logic                    cmd_oe,
    output logic [MEM_CK_WIDTH-1:0] mem_ck_en
);

    // one full-rate beat between serializer and pin registers
    ac_cmd_if beat_if ();

    // ************************************************************
    // phase, serializer and pin stage
    // ************************************************************

    ac_phase_gen i_ac_phase_gen (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (afi_load)
    );

    ac_beat_serializer i_ac_beat_serializer (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (afi_load),
        .afi_addr    (afi_addr),
        .afi_bank    (afi_bank),
        .afi_cs_n    (afi_cs_n),
        .afi_cke     (afi_cke),
        .afi_odt     (afi_odt),
        .afi_ras_n   (afi_ras_n),
        .afi_cas_n   (afi_cas_n),
        .afi_we_n    (afi_we_n),
        .beat        (beat_if.src)
    );

    // pins trail the load edge by two cycles for beat 0, three for beat 1
    ac_output_stage #(
        .MEM_CK_WIDTH (MEM_CK_WIDTH)
    ) i_ac_output_stage (
        .pll_mem_clk    (pll_mem_clk),
        .rst_n          (rst_n),
        .enable_mem_clk (enable_mem_clk),
        .beat           (beat_if.dst),
        .mem_addr       (mem_addr),
        .mem_bank       (mem_bank),
        .mem_cs_n       (mem_cs_n),
        .mem_cke        (mem_cke),
        .mem_odt        (mem_odt),
        .mem_ras_n      (mem_ras_n),
        .mem_cas_n      (mem_cas_n),
        .mem_we_n       (mem_we_n),
        .cmd_oe         (cmd_oe),
        .mem_ck_en      (mem_ck_en)
    );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// testbench clock and reset source for the memory clock domain
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic pll_mem_clk,
    output logic rst_n
);

    initial
    begin
        pll_mem_clk = 1'b0;
        forever #2 pll_mem_clk = ~pll_mem_clk;
    end

    // reset is held for four rising edges and released just after the last one
    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge pll_mem_clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/ac_pads_checker.sv
// concurrent assertions on the load phase and on command gating
`timescale 1ns/1ps
`default_nettype none

module ac_pads_checker (
    input logic                  pll_mem_clk,
    input logic                  rst_n,
    input logic                  load,
    input logic                  cmd_oe,
    input mem_geom_pkg::mem_cs_t cs_n
);

    // load is a single-cycle strobe
    load_single: assert property (@(posedge pll_mem_clk) disable iff (!rst_n)
        load |=> !load)
        else $error("load stayed high for two cycles");

    // and it comes back exactly two cycles later
    load_period: assert property (@(posedge pll_mem_clk) disable iff (!rst_n)
        load |-> ##2 load)
        else $error("load did not return two cycles after a pulse");

    // a disabled command bus must read as a deselect
    gate_deselect: assert property (@(posedge pll_mem_clk) disable iff (!rst_n)
        !cmd_oe |-> (cs_n == '1))
        else $error("cs_n active while cmd_oe is low");

endmodule

`default_nettype wire

// File: tb/ac_pads_monitor.sv
// watches the memory pins and compares them with the expected beats of each word
`timescale 1ns/1ps
`default_nettype none

module ac_pads_monitor #(
    parameter int MEM_CK_WIDTH = 1
) (
    input  logic                    pll_mem_clk,
    input  logic                    rst_n,
    input  logic                    afi_load,
    input  logic                    exp_valid,
    input  logic [20:0]             exp_beat0,
    input  logic [20:0]             exp_beat1,
    input  logic [MEM_CK_WIDTH-1:0] exp_en,
    input  mem_geom_pkg::mem_addr_t mem_addr,
    input  mem_geom_pkg::mem_bank_t mem_bank,
    input  mem_geom_pkg::mem_cs_t   mem_cs_n,
    input  mem_geom_pkg::mem_cke_t  mem_cke,
    input  mem_geom_pkg::mem_odt_t  mem_odt,
    input  logic                    mem_ras_n,
    input  logic                    mem_cas_n,
    input  logic                    mem_we_n,
    input  logic                    cmd_oe,
    input  logic [MEM_CK_WIDTH-1:0] mem_ck_en,
    output int                      error_count,
    output int                      test_count
);

    int test_errors;
    logic reset_applied;
    logic captured_any;
    logic phase_started;
    logic load_prev;

    // words in flight, stage n holds the word taken n edges ago
    logic v1, v2, v3;
    logic [20:0] p1_b0, p1_b1, p2_b0, p2_b1, p3_b1;
    logic [MEM_CK_WIDTH-1:0] p1_en, p2_en, p3_en;

    initial
    begin
        error_count   = 0;
        test_count    = 0;
        test_errors   = 0;
        reset_applied = 1'b0;
        captured_any  = 1'b0;
        phase_started = 1'b0;
        load_prev     = 1'b0;
        v1 = 1'b0;
        v2 = 1'b0;
        v3 = 1'b0;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, want);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic compare_pins(input logic [20:0] want, input logic [MEM_CK_WIDTH-1:0] en);
        check_value("mem_addr", 32'(mem_addr), 32'(want[20:8]));
        check_value("mem_bank", 32'(mem_bank), 32'(want[7:6]));
        check_value("mem_cs_n", 32'(mem_cs_n), 32'(want[5]));
        check_value("mem_cke", 32'(mem_cke), 32'(want[4]));
        check_value("mem_odt", 32'(mem_odt), 32'(want[3]));
        check_value("mem_ras_n", 32'(mem_ras_n), 32'(want[2]));
        check_value("mem_cas_n", 32'(mem_cas_n), 32'(want[1]));
        check_value("mem_we_n", 32'(mem_we_n), 32'(want[0]));
        check_value("cmd_oe", 32'(cmd_oe), 32'(|en));
        check_value("mem_ck_en", 32'(mem_ck_en), 32'(en));
    endtask

    // ************************************************************
    // per-edge checks, made on the values before the edge updates them
    // ************************************************************

    always @(posedge pll_mem_clk)
    begin
        // pins keep their reset values until the first word reaches them
        if (reset_applied && !captured_any)
        begin
            compare_pins(21'h00003f & 21'h000027, '0);
        end
        if (rst_n === 1'b0)
        begin
            reset_applied = 1'b1;
        end

        if (phase_started && afi_load === load_prev)
        begin
            $display("afi_load failed to alternate at %0t", $time);
            error_count++;
        end
        if (afi_load === 1'b1)
        begin
            phase_started = 1'b1;
        end
        load_prev = afi_load;

        if (v2)
        begin
            test_errors = 0;
            compare_pins(p2_b0, p2_en);
        end
        if (v3)
        begin
            compare_pins(p3_b1, p3_en);
            test_count++;
            $display("test %0d: %s", test_count, (test_errors == 0) ? "pass" : "fail");
        end

        v3    = v2;
        p3_b1 = p2_b1;
        p3_en = p2_en;
        v2    = v1;
        p2_b0 = p1_b0;
        p2_b1 = p1_b1;
        p2_en = p1_en;
        v1    = (afi_load === 1'b1) && exp_valid;
        p1_b0 = exp_beat0;
        p1_b1 = exp_beat1;
        p1_en = exp_en;

        // the reset check counts as the first test
        if (v1 && !captured_any)
        begin
            captured_any = 1'b1;
            test_count++;
            $display("test %0d (reset values): %s", test_count,
                     (test_errors == 0) ? "pass" : "fail");
        end
    end

endmodule

`default_nettype wire

// File: tb/ac_pads_tb.sv
// testbench for the half-rate to full-rate address/command converter
`timescale 1ns/1ps
`default_nettype none

module ac_pads_tb;

    import mem_geom_pkg::*;
    import afi_cmd_pkg::*;

    localparam int          MEM_CK_WIDTH  = 2;
    localparam int          N_FIXED       = 6;
    localparam int          N_ROWS        = 16;
    localparam int          LOAD_TIMEOUT  = 16;
    localparam int          DRAIN_TIMEOUT = 20;
    localparam logic [31:0] SEED          = 32'hd81b_7698;

    logic pll_mem_clk;
    logic rst_n;
    logic [MEM_CK_WIDTH-1:0] enable_mem_clk;
    afi_addr_t afi_addr;
    afi_bank_t afi_bank;
    afi_cs_t   afi_cs_n;
    afi_cke_t  afi_cke;
    afi_odt_t  afi_odt;
    afi_ctl_t  afi_ras_n;
    afi_ctl_t  afi_cas_n;
    afi_ctl_t  afi_we_n;
    logic      afi_load;
    mem_addr_t mem_addr;
    mem_bank_t mem_bank;
    mem_cs_t   mem_cs_n;
    mem_cke_t  mem_cke;
    mem_odt_t  mem_odt;
    logic      mem_ras_n;
    logic      mem_cas_n;
    logic      mem_we_n;
    logic      cmd_oe;
    logic [MEM_CK_WIDTH-1:0] mem_ck_en;

    logic exp_valid;
    logic [20:0] exp_beat0;
    logic [20:0] exp_beat1;
    logic [MEM_CK_WIDTH-1:0] exp_en;
    int error_count;
    int test_count;

    // ************************************************************
    // stimulus and expected-value table
    // ************************************************************

    afi_addr_t t_addr [N_ROWS];
    afi_bank_t t_bank [N_ROWS];
    afi_cs_t   t_cs   [N_ROWS];
    afi_cke_t  t_cke  [N_ROWS];
    afi_odt_t  t_odt  [N_ROWS];
    afi_ctl_t  t_ras  [N_ROWS];
    afi_ctl_t  t_cas  [N_ROWS];
    afi_ctl_t  t_we   [N_ROWS];
    logic [MEM_CK_WIDTH-1:0] t_en [N_ROWS];
    logic [20:0] t_exp0 [N_ROWS];
    logic [20:0] t_exp1 [N_ROWS];
    logic [31:0] rng_state;

    tb_clk_gen i_clk_gen (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n)
    );

    ac_pads_top #(
        .MEM_CK_WIDTH (MEM_CK_WIDTH)
    ) i_ac_pads_top (
        .pll_mem_clk    (pll_mem_clk),
        .rst_n          (rst_n),
        .enable_mem_clk (enable_mem_clk),
        .afi_addr       (afi_addr),
        .afi_bank       (afi_bank),
        .afi_cs_n       (afi_cs_n),
        .afi_cke        (afi_cke),
        .afi_odt        (afi_odt),
        .afi_ras_n      (afi_ras_n),
        .afi_cas_n      (afi_cas_n),
        .afi_we_n       (afi_we_n),
        .afi_load       (afi_load),
        .mem_addr       (mem_addr),
        .mem_bank       (mem_bank),
        .mem_cs_n       (mem_cs_n),
        .mem_cke        (mem_cke),
        .mem_odt        (mem_odt),
        .mem_ras_n      (mem_ras_n),
        .mem_cas_n      (mem_cas_n),
        .mem_we_n       (mem_we_n),
        .cmd_oe         (cmd_oe),
        .mem_ck_en      (mem_ck_en)
    );

    ac_pads_monitor #(
        .MEM_CK_WIDTH (MEM_CK_WIDTH)
    ) i_monitor (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .afi_load    (afi_load),
        .exp_valid   (exp_valid),
        .exp_beat0   (exp_beat0),
        .exp_beat1   (exp_beat1),
        .exp_en      (exp_en),
        .mem_addr    (mem_addr),
        .mem_bank    (mem_bank),
        .mem_cs_n    (mem_cs_n),
        .mem_cke     (mem_cke),
        .mem_odt     (mem_odt),
        .mem_ras_n   (mem_ras_n),
        .mem_cas_n   (mem_cas_n),
        .mem_we_n    (mem_we_n),
        .cmd_oe      (cmd_oe),
        .mem_ck_en   (mem_ck_en),
        .error_count (error_count),
        .test_count  (test_count)
    );

    bind ac_phase_gen ac_pads_checker i_phase_checker (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (load),
        .cmd_oe      (1'b1),
        .cs_n        (1'b1)
    );

    bind ac_output_stage ac_pads_checker i_gating_checker (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (1'b0),
        .cmd_oe      (cmd_oe),
        .cs_n        (mem_cs_n)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // one beat is the low or high half of every field, forced inactive
    // except for cke when no memory clock runs
    function automatic logic [20:0] expected_beat(input int idx, input int half);
        logic [12:0] a;
        logic [1:0]  b;
        logic        cs;
        logic        ck;
        logic        od;
        logic        ra;
        logic        ca;
        logic        we;
        a  = t_addr[idx][half*13 +: 13];
        b  = t_bank[idx][half*2 +: 2];
        cs = t_cs[idx][half];
        ck = t_cke[idx][half];
        od = t_odt[idx][half];
        ra = t_ras[idx][half];
        ca = t_cas[idx][half];
        we = t_we[idx][half];
        if (t_en[idx] == '0)
        begin
            a  = '0;
            b  = '0;
            cs = 1'b1;
            od = 1'b0;
            ra = 1'b1;
            ca = 1'b1;
            we = 1'b1;
        end
        return {a, b, cs, ck, od, ra, ca, we};
    endfunction

    task automatic set_row(input int i, input afi_addr_t a, input afi_bank_t b,
                           input afi_cs_t cs, input afi_cke_t ck, input afi_odt_t od,
                           input afi_ctl_t ra, input afi_ctl_t ca, input afi_ctl_t we,
                           input logic [MEM_CK_WIDTH-1:0] en);
        t_addr[i] = a;
        t_bank[i] = b;
        t_cs[i]   = cs;
        t_cke[i]  = ck;
        t_odt[i]  = od;
        t_ras[i]  = ra;
        t_cas[i]  = ca;
        t_we[i]   = we;
        t_en[i]   = en;
    endtask

    task automatic fill_table();
        logic [31:0] r1;
        logic [31:0] r2;
        // rows 2 and 3 run with every memory clock stopped
        set_row(0, {13'h0155, 13'h1aaa}, 4'b1001, 2'b10, 2'b11, 2'b01, 2'b10, 2'b01, 2'b11, 2'b01);
        set_row(1, {13'h1fff, 13'h0001}, 4'b0011, 2'b01, 2'b11, 2'b10, 2'b01, 2'b10, 2'b00, 2'b10);
        set_row(2, {13'h0abc, 13'h1234}, 4'b1111, 2'b00, 2'b10, 2'b11, 2'b00, 2'b00, 2'b00, 2'b00);
        set_row(3, {13'h0f0f, 13'h10f0}, 4'b0110, 2'b00, 2'b01, 2'b11, 2'b01, 2'b00, 2'b10, 2'b00);
        set_row(4, {13'h1555, 13'h0aaa}, 4'b1100, 2'b10, 2'b11, 2'b00, 2'b11, 2'b11, 2'b01, 2'b11);
        set_row(5, '0, '0, '0, '0, '0, '0, '0, '0, 2'b01);
        rng_state = SEED;
        for (int i = N_FIXED; i < N_ROWS; i++)
        begin
            rng_state = next_random(rng_state);
            r1 = rng_state;
            rng_state = next_random(rng_state);
            r2 = rng_state;
            set_row(i, r1[25:0], r2[3:0], r2[5:4], r2[7:6], r2[9:8], r2[11:10],
                    r2[13:12], r2[15:14], r2[17:16]);
        end
        for (int i = 0; i < N_ROWS; i++)
        begin
            t_exp0[i] = expected_beat(i, 0);
            t_exp1[i] = expected_beat(i, 1);
        end
    endtask

    // returns a small delay after the edge that precedes a load edge
    task automatic wait_for_load(output logic timed_out);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge pll_mem_clk);
            #1;
            cycles++;
        end
        while (afi_load !== 1'b1 && cycles < LOAD_TIMEOUT);
        timed_out = (afi_load !== 1'b1);
        if (timed_out)
        begin
            $display("timeout: afi_load did not pulse within %0d cycles", LOAD_TIMEOUT);
        end
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************

    initial
    begin
        int   waited;
        logic timed_out;
        enable_mem_clk = '0;
        afi_addr  = '0;
        afi_bank  = '0;
        afi_cs_n  = '1;
        afi_cke   = '0;
        afi_odt   = '0;
        afi_ras_n = '1;
        afi_cas_n = '1;
        afi_we_n  = '1;
        exp_valid = 1'b0;
        exp_beat0 = '0;
        exp_beat1 = '0;
        exp_en    = '0;
        timed_out = 1'b0;
        fill_table();

        for (int i = 0; i < N_ROWS && !timed_out; i++)
        begin
            wait_for_load(timed_out);
            if (!timed_out)
            begin
                afi_addr  = t_addr[i];
                afi_bank  = t_bank[i];
                afi_cs_n  = t_cs[i];
                afi_cke   = t_cke[i];
                afi_odt   = t_odt[i];
                afi_ras_n = t_ras[i];
                afi_cas_n = t_cas[i];
                afi_we_n  = t_we[i];
                exp_valid = 1'b1;
                exp_beat0 = t_exp0[i];
                exp_beat1 = t_exp1[i];
                exp_en    = t_en[i];
                // the enable covers the two edges that move this word's beats to the pins
                @(posedge pll_mem_clk);
                #1 enable_mem_clk = t_en[i];
            end
        end
        if (!timed_out)
        begin
            wait_for_load(timed_out);
            exp_valid = 1'b0;
        end

        waited = 0;
        while (!timed_out && test_count < N_ROWS + 1 && waited < DRAIN_TIMEOUT)
        begin
            @(posedge pll_mem_clk);
            #1;
            waited++;
        end
        if (!timed_out && test_count != N_ROWS + 1)
        begin
            $display("timeout: only %0d of %0d tests completed", test_count, N_ROWS + 1);
        end
        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (!timed_out && error_count == 0 && test_count == N_ROWS + 1)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/mem_geom_pkg.sv
rtl/afi_cmd_pkg.sv
rtl/ac_cmd_if.sv
rtl/ac_phase_gen.sv
rtl/ac_beat_serializer.sv
rtl/ac_output_stage.sv
rtl/ac_pads_top.sv
tb/tb_clk_gen.sv
tb/ac_pads_checker.sv
tb/ac_pads_monitor.sv
tb/ac_pads_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ac_pads_tb \
    -f src.f \
    -o ac_pads_sim

sim_output=$(./obj_dir/ac_pads_sim)
echo "$sim_output"

echo "$sim_output" | grep -q "ALL CHECKS PASSED"
